//--- common/vga_pkg.sv
package vga_pkg;

    // rgb444 colour, red in the top nibble
    typedef logic [11:0] pixel_t;

    // colour table index, all ones marks a see-through pixel
    typedef logic [3:0] cidx_t;

    // pattern table address {row, column}
    typedef logic [5:0] paddr_t;

    // screen coordinate, wide enough for any counter or position
    typedef logic [9:0] coord_t;

    // sprite edge in pixels, tied to the 64-entry pattern table
    localparam int unsigned SPRITE_SIZE = 8;

    // transparent colour index
    localparam cidx_t CIDX_TRANSPARENT = '1;

    // what a register write lands on
    typedef enum logic [2:0] {
        TGT_PTABLE = 3'd0,  // pattern table entry
        TGT_CTABLE = 3'd1,  // colour table entry
        TGT_POS_X  = 3'd2,  // sprite left edge
        TGT_POS_Y  = 3'd3,  // sprite top edge
        TGT_BG     = 3'd4   // background colour
    } reg_target_e;

    // one write on the register port
    typedef struct packed {
        reg_target_e target;
        logic [5:0]  index;  // 6 bits used for pattern, low 4 for colour
        logic [11:0] data;   // colour, index in [3:0] or coordinate
    } reg_wr_t;

    // table update strobe from the register block to the sprite store
    typedef struct packed {
        logic        ptable_we;
        logic        ctable_we;
        logic [5:0]  index;
        logic [11:0] data;
    } tbl_wr_t;

    // sprite controller states
    typedef enum logic [1:0] {
        S_IDLE     = 2'd0,  // waiting for the next frame
        S_WAIT_ROW = 2'd1,  // frame armed, waiting for a sprite line
        S_DRAW     = 2'd2,  // inside the sprite box on this line
        S_ROW_DONE = 2'd3   // one sprite row finished
    } sprite_state_e;

endpackage : vga_pkg

//--- vga/vga_timing.sv
`timescale 1ns/1ns

module vga_timing
    import vga_pkg::*;
#(
    parameter int unsigned H_ACTIVE = 32,
    parameter int unsigned H_FRONT  = 2,
    parameter int unsigned H_SYNC   = 4,
    parameter int unsigned H_BACK   = 2,
    parameter int unsigned V_ACTIVE = 24,
    parameter int unsigned V_FRONT  = 1,
    parameter int unsigned V_SYNC   = 2,
    parameter int unsigned V_BACK   = 1
) (
    input  logic   clk_i,
    input  logic   rst_n_i,

    output coord_t h_cnt_o,
    output coord_t v_cnt_o,
    output logic   active_o,
    output logic   vblank_o,
    output logic   frame_start_o,
    output logic   hsync_n_o,
    output logic   vsync_n_o
);

    localparam int unsigned H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int unsigned V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // sync windows, pulse starts right after the front porch
    localparam int unsigned H_SYNC_BEG = H_ACTIVE + H_FRONT;
    localparam int unsigned H_SYNC_END = H_SYNC_BEG + H_SYNC;
    localparam int unsigned V_SYNC_BEG = V_ACTIVE + V_FRONT;
    localparam int unsigned V_SYNC_END = V_SYNC_BEG + V_SYNC;

    coord_t h_cnt_q;
    coord_t v_cnt_q;
    logic   h_last;  // last column of a line
    logic   v_last;  // last line of a frame

    assign h_last = (h_cnt_q == coord_t'(H_TOTAL - 1));
    assign v_last = (v_cnt_q == coord_t'(V_TOTAL - 1));

    // column counter, wraps every line
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            h_cnt_q <= '0;
        end else if (h_last) begin
            h_cnt_q <= '0;
        end else begin
            h_cnt_q <= h_cnt_q + 1'b1;
        end
    end

    // line counter, steps at the end of each line
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            v_cnt_q <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_cnt_q <= '0;
            end else begin
                v_cnt_q <= v_cnt_q + 1'b1;
            end
        end
    end

    assign h_cnt_o = h_cnt_q;
    assign v_cnt_o = v_cnt_q;

    // flags are pure decodes of the counters, aligned with them
    assign active_o      = (h_cnt_q < coord_t'(H_ACTIVE)) && (v_cnt_q < coord_t'(V_ACTIVE));
    assign vblank_o      = (v_cnt_q >= coord_t'(V_ACTIVE));  // whole lines, porches included
    assign frame_start_o = (h_cnt_q == '0) && (v_cnt_q == '0);

    // syncs are active low
    assign hsync_n_o = !((h_cnt_q >= coord_t'(H_SYNC_BEG)) && (h_cnt_q < coord_t'(H_SYNC_END)));
    assign vsync_n_o = !((v_cnt_q >= coord_t'(V_SYNC_BEG)) && (v_cnt_q < coord_t'(V_SYNC_END)));

endmodule : vga_timing

//--- vga/vga_sprite_ctrl.sv
`timescale 1ns/1ns

module vga_sprite_ctrl
    import vga_pkg::*;
#(
    parameter int unsigned H_ACTIVE = 32,
    parameter int unsigned V_ACTIVE = 24
) (
    input  logic   clk_i,
    input  logic   rst_n_i,

    input  coord_t h_cnt_i,
    input  coord_t v_cnt_i,
    input  logic   active_i,
    input  logic   frame_start_i,

    input  coord_t sprite_x_i,
    input  coord_t sprite_y_i,

    output logic   sprite_rd_o,
    output logic   ptr_clr_o
);

    sprite_state_e state_q, state_d;
    coord_t        pos_x_q, pos_y_q;  // position frozen for the current frame
    logic [2:0]    row_q;             // sprite rows already drawn

    coord_t        cur_x, cur_y;      // position in effect this cycle
    logic [2:0]    cur_row;
    logic          armed;             // frame is live, sprite may still show
    logic          row_hit, col_hit;
    logic          last_col;

    // at frame start the registers still hold last frame, so take the live inputs
    assign cur_x   = frame_start_i ? sprite_x_i : pos_x_q;
    assign cur_y   = frame_start_i ? sprite_y_i : pos_y_q;
    assign cur_row = frame_start_i ? 3'd0 : row_q;

    assign armed   = (state_q != S_IDLE) || frame_start_i;
    assign row_hit = (v_cnt_i == cur_y + coord_t'(cur_row)) && (v_cnt_i < coord_t'(V_ACTIVE));
    assign col_hit = (h_cnt_i >= cur_x) && (h_cnt_i < cur_x + coord_t'(SPRITE_SIZE))
                   && (h_cnt_i < coord_t'(H_ACTIVE));
    assign last_col = (h_cnt_i == cur_x + coord_t'(SPRITE_SIZE - 1));

    // one read per pixel inside the 8x8 box, none while reset holds the counters at 0
    assign sprite_rd_o = armed && row_hit && col_hit && active_i && rst_n_i;
    assign ptr_clr_o   = frame_start_i;  // realign the store every frame

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (frame_start_i) begin
                    state_d = sprite_rd_o ? S_DRAW : S_WAIT_ROW;
                end
            end
            S_WAIT_ROW: begin
                if (sprite_rd_o) begin
                    state_d = S_DRAW;  // first column of the row
                end else if (v_cnt_i >= coord_t'(V_ACTIVE)) begin
                    state_d = S_IDLE;  // band missed, give up until next frame
                end
            end
            S_DRAW: begin
                if (!sprite_rd_o || last_col) begin
                    state_d = S_ROW_DONE;
                end
            end
            S_ROW_DONE: begin
                state_d = (row_q == 3'd7) ? S_IDLE : S_WAIT_ROW;
            end
            default: state_d = S_IDLE;
        endcase
        // a new frame always restarts the walk
        if (frame_start_i && state_q != S_IDLE) begin
            state_d = sprite_rd_o ? S_DRAW : S_WAIT_ROW;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            pos_x_q <= '0;
            pos_y_q <= '0;
            row_q   <= '0;
        end else begin
            state_q <= state_d;
            if (frame_start_i) begin
                pos_x_q <= sprite_x_i;  // sampled once, no shear mid-frame
                pos_y_q <= sprite_y_i;
                row_q   <= '0;
            end else if (state_q == S_ROW_DONE) begin
                row_q <= row_q + 1'b1;  // wraps to 0 after row 7
            end
        end
    end

endmodule : vga_sprite_ctrl

//--- sprite/vga_sprite.sv
`timescale 1ns/1ns

module vga_sprite
    import vga_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,

    // from the sprite controller
    input  logic    read_i,
    input  logic    clr_i,

    // from the register block
    input  tbl_wr_t tbl_wr_i,

    output pixel_t  pixel_o,
    output logic    transparent_o
);

    // 16 colours shared by every sprite pixel
    pixel_t color_table [16];

    // 8x8 sprite, one colour index per pixel, row major
    cidx_t  pattern_table [64];

    paddr_t read_ptr_q;
    cidx_t  cur_idx;  // index of the pixel under the pointer

    // power-up contents, red ramp and repeating index pattern
    initial begin
        for (int i = 0; i < 16; i++) begin
            color_table[i] = pixel_t'(i * 256);
        end
        for (int i = 0; i < 64; i++) begin
            pattern_table[i] = cidx_t'(i % 16);
        end
    end

    always_ff @(posedge clk_i) begin
        if (tbl_wr_i.ctable_we) begin
            color_table[tbl_wr_i.index[3:0]] <= tbl_wr_i.data;  // only 16 entries
        end
    end

    always_ff @(posedge clk_i) begin
        if (tbl_wr_i.ptable_we) begin
            pattern_table[tbl_wr_i.index] <= tbl_wr_i.data[3:0];
        end
    end

    // pointer walks the pattern table once per frame, 63 wraps to 0
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            read_ptr_q <= '0;
        end else if (clr_i) begin
            read_ptr_q <= read_i ? paddr_t'(1) : '0;  // a read can land on the clear cycle
        end else if (read_i) begin
            read_ptr_q <= read_ptr_q + 1'b1;
        end
    end

    // two-level lookup, pattern gives the index and the table gives the colour
    assign cur_idx       = pattern_table[read_ptr_q];
    assign pixel_o       = color_table[cur_idx];
    assign transparent_o = (cur_idx == CIDX_TRANSPARENT);

endmodule : vga_sprite

//--- logic/vga_regs.sv
`timescale 1ns/1ns

module vga_regs
    import vga_pkg::*;
#(
    parameter int unsigned H_ACTIVE = 32,
    parameter int unsigned V_ACTIVE = 24
) (
    input  logic    clk_i,
    input  logic    rst_n_i,

    // write port
    input  logic    wr_valid_i,
    input  reg_wr_t wr_i,
    output logic    wr_ready_o,

    input  logic    vblank_i,

    output tbl_wr_t tbl_wr_o,
    output coord_t  sprite_x_o,
    output coord_t  sprite_y_o,
    output pixel_t  bg_colour_o
);

    // largest positions that keep the whole sprite on screen
    localparam int unsigned MAX_X = H_ACTIVE - SPRITE_SIZE;
    localparam int unsigned MAX_Y = V_ACTIVE - SPRITE_SIZE;

    logic xfer;  // write handshake completes this cycle

    // compare on the full 12 bits so large values do not wrap into range
    function automatic coord_t clamp_pos(input logic [11:0] val, input int unsigned lim);
        if (val > 12'(lim)) begin
            return coord_t'(lim);
        end
        return coord_t'(val);
    endfunction

    // tables only change between frames
    assign wr_ready_o = vblank_i;
    assign xfer       = wr_valid_i && wr_ready_o;

    // single-cycle strobe into the sprite store
    always_comb begin
        tbl_wr_o           = '0;
        tbl_wr_o.index     = wr_i.index;
        tbl_wr_o.data      = wr_i.data;
        tbl_wr_o.ptable_we = xfer && (wr_i.target == TGT_PTABLE);
        tbl_wr_o.ctable_we = xfer && (wr_i.target == TGT_CTABLE);
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sprite_x_o  <= '0;
            sprite_y_o  <= '0;
            bg_colour_o <= '0;
        end else if (xfer) begin
            case (wr_i.target)
                TGT_POS_X: sprite_x_o  <= clamp_pos(wr_i.data, MAX_X);
                TGT_POS_Y: sprite_y_o  <= clamp_pos(wr_i.data, MAX_Y);
                TGT_BG:    bg_colour_o <= wr_i.data;
                default:   ;  // table targets go out on tbl_wr_o
            endcase
        end
    end

endmodule : vga_regs

//--- vga/vga_top.sv
`timescale 1ns/1ns

module vga_top
    import vga_pkg::*;
#(
    parameter int unsigned H_ACTIVE = 32,
    parameter int unsigned H_FRONT  = 2,
    parameter int unsigned H_SYNC   = 4,
    parameter int unsigned H_BACK   = 2,
    parameter int unsigned V_ACTIVE = 24,
    parameter int unsigned V_FRONT  = 1,
    parameter int unsigned V_SYNC   = 2,
    parameter int unsigned V_BACK   = 1
) (
    input  logic    clk_i,
    input  logic    rst_n_i,

    input  logic    wr_valid_i,
    input  reg_wr_t wr_i,
    output logic    wr_ready_o,

    output pixel_t  rgb_o,
    output logic    hsync_n_o,
    output logic    vsync_n_o
);

    coord_t  h_cnt, v_cnt;
    logic    active, vblank, frame_start;
    logic    hsync_n, vsync_n;        // raw syncs before the output register
    coord_t  sprite_x, sprite_y;
    pixel_t  bg_colour;
    tbl_wr_t tbl_wr;
    logic    sprite_rd, ptr_clr;
    pixel_t  spr_pixel;
    logic    spr_transparent;
    pixel_t  rgb_d;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) timing_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .h_cnt_o(h_cnt), .v_cnt_o(v_cnt), .active_o(active), .vblank_o(vblank),
        .frame_start_o(frame_start), .hsync_n_o(hsync_n), .vsync_n_o(vsync_n)
    );

    vga_regs #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) regs_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .wr_valid_i(wr_valid_i), .wr_i(wr_i), .wr_ready_o(wr_ready_o),
        .vblank_i(vblank), .tbl_wr_o(tbl_wr),
        .sprite_x_o(sprite_x), .sprite_y_o(sprite_y), .bg_colour_o(bg_colour)
    );

    vga_sprite_ctrl #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) ctrl_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .h_cnt_i(h_cnt), .v_cnt_i(v_cnt), .active_i(active), .frame_start_i(frame_start),
        .sprite_x_i(sprite_x), .sprite_y_i(sprite_y),
        .sprite_rd_o(sprite_rd), .ptr_clr_o(ptr_clr)
    );

    vga_sprite sprite_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .read_i(sprite_rd), .clr_i(ptr_clr), .tbl_wr_i(tbl_wr),
        .pixel_o(spr_pixel), .transparent_o(spr_transparent)
    );

    // sprite over background, black in blanking
    assign rgb_d = (sprite_rd && !spr_transparent) ? spr_pixel :
                   active                          ? bg_colour : '0;

    // colour and syncs leave together, one cycle behind the counters
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rgb_o     <= '0;
            hsync_n_o <= 1'b1;
            vsync_n_o <= 1'b1;
        end else begin
            rgb_o     <= rgb_d;
            hsync_n_o <= hsync_n;
            vsync_n_o <= vsync_n;
        end
    end

endmodule : vga_top

//--- tests/vga_chk.sv
`timescale 1ns/1ns

module vga_chk
    import vga_pkg::*;
#(
    parameter int unsigned H_SYNC   = 4,
    parameter int unsigned V_ACTIVE = 24
) (
    input logic    clk_i,
    input logic    rst_n_i,
    input logic    wr_valid_i,
    input reg_wr_t wr_i,
    input logic    wr_ready_i,
    input coord_t  v_cnt_i,
    input logic    hsync_n_i
);

    logic [7:0] low_cnt;  // length of the current hsync pulse

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            low_cnt <= '0;
        end else if (!hsync_n_i) begin
            low_cnt <= low_cnt + 8'd1;
        end else begin
            low_cnt <= '0;
        end
    end

    // a stalled write keeps its payload
    hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wr_valid_i && !wr_ready_i) |=> (wr_valid_i && $stable(wr_i)))
        else $error("write payload changed while stalled");

    // port only opens on the lines below the active area
    ready_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_ready_i |-> (v_cnt_i >= coord_t'(V_ACTIVE)))
        else $error("write port ready outside vblank");

    hsync_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(hsync_n_i) |-> (low_cnt == 8'(H_SYNC)))
        else $error("hsync pulse has the wrong length");

endmodule : vga_chk

bind vga_top vga_chk #(.H_SYNC(H_SYNC), .V_ACTIVE(V_ACTIVE)) chk_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .wr_valid_i(wr_valid_i), .wr_i(wr_i), .wr_ready_i(wr_ready_o),
    .v_cnt_i(v_cnt), .hsync_n_i(hsync_n_o)
);

//--- tests/tb_vga.sv
`timescale 1ns/1ns

module tb_vga
    import vga_pkg::*;
;

    // default timing of vga_top
    localparam int H_ACTIVE   = 32;
    localparam int H_TOTAL    = 40;  // 32 + 2 + 4 + 2
    localparam int V_ACTIVE   = 24;
    localparam int V_TOTAL    = 28;  // 24 + 1 + 2 + 1
    localparam int H_SYNC_BEG = 34;
    localparam int H_SYNC_END = 38;
    localparam int V_SYNC_BEG = 25;
    localparam int V_SYNC_END = 27;
    localparam int FRAME      = H_TOTAL * V_TOTAL;
    localparam int EDGE       = 8;       // sprite is 8x8
    localparam int NUM_FRAMES = 8;
    localparam int WR_TIMEOUT = 2 * FRAME;

    logic    clk_i;
    logic    rst_n_i;
    logic    wr_valid_i;
    reg_wr_t wr_i;
    logic    wr_ready_o;
    pixel_t  rgb_o;
    logic    hsync_n_o;
    logic    vsync_n_o;

    // reference image state
    pixel_t      m_ctab [16];
    cidx_t       m_ptab [64];
    int          m_x, m_y;
    pixel_t      m_bg;

    logic [31:0] rng;
    int          offered, accepted, held_off;  // held_off counts writes offered outside vblank
    int          pend_cycles;                  // cycles the current write has waited
    int          gap;                          // idle cycles before the next write
    logic        accept_seen;                  // write goes through at the coming edge

    vga_top dut_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .wr_valid_i(wr_valid_i), .wr_i(wr_i), .wr_ready_o(wr_ready_o),
        .rgb_o(rgb_o), .hsync_n_o(hsync_n_o), .vsync_n_o(vsync_n_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // handshakes the DUT really takes, counted at the transfer edge
    always @(posedge clk_i) begin
        if (rst_n_i && wr_valid_i && wr_ready_o) begin
            accepted = accepted + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic roll(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
        if (got_v !== exp_v) begin
            $display("ERR %s exp %0h got %0h", name, exp_v, got_v);
            abort_run("value mismatch");
        end
    endtask

    function automatic int h_of(input int p);
        return p % H_TOTAL;
    endfunction

    function automatic int v_of(input int p);
        return (p / H_TOTAL) % V_TOTAL;
    endfunction

    // colour expected on screen for linear position p
    function automatic pixel_t expect_rgb(input int p);
        int    h, v;
        cidx_t ci;
        h = h_of(p);
        v = v_of(p);
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return '0;  // blanking is black
        end
        if (h >= m_x && h < m_x + EDGE && v >= m_y && v < m_y + EDGE) begin
            ci = m_ptab[(v - m_y) * EDGE + (h - m_x)];
            if (ci != 4'hf) begin
                return m_ctab[ci];
            end
        end
        return m_bg;  // background, also behind see-through pixels
    endfunction

    function automatic logic expect_hs(input int p);
        return !(h_of(p) >= H_SYNC_BEG && h_of(p) < H_SYNC_END);
    endfunction

    function automatic logic expect_vs(input int p);
        return !(v_of(p) >= V_SYNC_BEG && v_of(p) < V_SYNC_END);
    endfunction

    // reference side of an accepted write, positions clamped to keep the sprite on screen
    task automatic apply_write(input reg_wr_t w);
        case (w.target)
            TGT_PTABLE: m_ptab[w.index] = w.data[3:0];
            TGT_CTABLE: m_ctab[w.index[3:0]] = w.data;
            TGT_POS_X:  m_x = (int'(w.data) > H_ACTIVE - EDGE) ? H_ACTIVE - EDGE : int'(w.data);
            TGT_POS_Y:  m_y = (int'(w.data) > V_ACTIVE - EDGE) ? V_ACTIVE - EDGE : int'(w.data);
            TGT_BG:     m_bg = w.data;
            default:    ;
        endcase
    endtask

    task automatic offer_write();
        logic [31:0] r, d;
        reg_wr_t     w;
        roll(r);
        roll(d);
        w.target = reg_target_e'(3'(r % 5));
        w.index  = r[13:8];
        case (w.target)
            TGT_POS_X, TGT_POS_Y: w.data = d[0] ? 12'(d[31:20] % 40) : d[31:20];  // some clamp
            TGT_PTABLE:           w.data = d[1] ? 12'h00f : {8'h00, d[23:20]};  // extra holes
            default:              w.data = d[31:20];
        endcase
        wr_i        = w;
        wr_valid_i  = 1'b1;
        offered     = offered + 1;
        pend_cycles = 0;
        if (!wr_ready_o) begin
            held_off = held_off + 1;  // has to wait for vblank
        end
    endtask

    // write port, called once per falling edge with the counter position
    task automatic drive_writes(input int pos);
        logic [31:0] r;
        if (accept_seen) begin
            wr_valid_i  = 1'b0;  // went through at the last rising edge
            accept_seen = 1'b0;
            roll(r);
            gap = int'(r % 6);
        end else if (wr_valid_i) begin
            pend_cycles = pend_cycles + 1;
            if (pend_cycles > WR_TIMEOUT) begin
                abort_run("a pending write was not accepted within two frames");
            end
        end else if (gap > 0) begin
            gap = gap - 1;
        end else if (pos / FRAME >= 2 && pos / FRAME < NUM_FRAMES - 1) begin
            offer_write();  // last frame stays quiet so every write drains
        end
        if (wr_valid_i && wr_ready_o) begin
            apply_write(wr_i);
            accept_seen = 1'b1;
        end
    endtask

    initial begin
        int pos;
        rng         = 32'd3;
        rst_n_i     = 1'b0;
        wr_valid_i  = 1'b0;
        wr_i        = '0;
        offered     = 0;
        accepted    = 0;
        held_off    = 0;
        pend_cycles = 0;
        gap         = 0;
        accept_seen = 1'b0;
        m_x         = 0;
        m_y         = 0;
        m_bg        = '0;
        for (int i = 0; i < 16; i++) begin
            m_ctab[i] = pixel_t'(i << 8);  // red ramp
        end
        for (int i = 0; i < 64; i++) begin
            m_ptab[i] = cidx_t'(i & 15);
        end

        repeat (8) @(negedge clk_i);
        check_val("rgb_o", 32'h0, 32'(rgb_o));
        check_val("hsync_n_o", 32'h1, 32'(hsync_n_o));
        check_val("vsync_n_o", 32'h1, 32'(vsync_n_o));
        check_val("wr_ready_o", 32'h0, 32'(wr_ready_o));
        rst_n_i = 1'b1;

        // counters sit at pos here, outputs show pos - 1
        for (pos = 1; pos <= NUM_FRAMES * FRAME; pos++) begin
            @(negedge clk_i);
            check_val("rgb_o", 32'(expect_rgb(pos - 1)), 32'(rgb_o));
            check_val("hsync_n_o", 32'(expect_hs(pos - 1)), 32'(hsync_n_o));
            check_val("vsync_n_o", 32'(expect_vs(pos - 1)), 32'(vsync_n_o));
            check_val("wr_ready_o", 32'(v_of(pos) >= V_ACTIVE), 32'(wr_ready_o));
            drive_writes(pos);
        end

        check_val("writes_accepted", 32'(offered), 32'(accepted));
        if (held_off == 0) begin
            abort_run("no write was ever held off during active video");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule : tb_vga

//--- project.f
common/vga_pkg.sv
vga/vga_timing.sv
vga/vga_sprite_ctrl.sv
sprite/vga_sprite.sv
logic/vga_regs.sv
vga/vga_top.sv
tests/vga_chk.sv
tests/tb_vga.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the VGA sprite testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_vga -f project.f -o sim_vga

# the simulator status is not trusted, the log decides
./obj_dir/sim_vga 2>&1 | tee sim.log

if grep -qF "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
